// File: Bender.yml
package:
  name: hacd_read

sources:
  - hw/hacd_pkg.sv
  - hw/axird_fifo_master.sv
  - hw/page_zero_scan.sv
  - hw/page_checksum.sv
  - hw/axird_arbiter.sv
  - hw/hacd_read_top.sv
  - target: test
    files:
      - test/axi_mem_model.sv
      - test/tb_hacd_read.sv

// File: build.f
hw/hacd_pkg.sv
hw/axird_fifo_master.sv
hw/page_zero_scan.sv
hw/page_checksum.sv
hw/axird_arbiter.sv
hw/hacd_read_top.sv
test/axi_mem_model.sv
test/tb_hacd_read.sv

// File: hw/axird_arbiter.sv
// two-way burst arbiter for the read port
`timescale 1ns/1ps

module axird_arbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [hacd_pkg::addr_width-1:0] a0_araddr,
    input  logic [7:0]                      a0_arlen,
    input  logic                            a0_arvalid,
    input  logic                            a0_rready,
    output logic                            a0_arready,
    output logic [hacd_pkg::data_width-1:0] a0_rdata,
    output logic [1:0]                      a0_rresp,
    output logic                            a0_rlast,
    output logic                            a0_rvalid,
    input  logic [hacd_pkg::addr_width-1:0] a1_araddr,
    input  logic [7:0]                      a1_arlen,
    input  logic                            a1_arvalid,
    input  logic                            a1_rready,
    output logic                            a1_arready,
    output logic [hacd_pkg::data_width-1:0] a1_rdata,
    output logic [1:0]                      a1_rresp,
    output logic                            a1_rlast,
    output logic                            a1_rvalid,
    output logic [hacd_pkg::addr_width-1:0] mem_araddr,
    output logic [7:0]                      mem_arlen,
    output logic                            mem_arvalid,
    output logic                            mem_rready,
    input  logic                            mem_arready,
    input  logic [hacd_pkg::data_width-1:0] mem_rdata,
    input  logic [1:0]                      mem_rresp,
    input  logic                            mem_rlast,
    input  logic                            mem_rvalid
);

    logic owned;
    logic owner;
    logic ar_sent;
    logic last_winner;
    logic pick;
    logic ar_open;

    // alternate on ties, else whoever asks
    always_comb begin
        if (a0_arvalid && a1_arvalid) begin
            pick = !last_winner;
        end else begin
            pick = a1_arvalid;
        end
    end

    assign ar_open     = owned && !ar_sent;
    assign mem_araddr  = owner ? a1_araddr : a0_araddr;
    assign mem_arlen   = owner ? a1_arlen : a0_arlen;
    assign mem_arvalid = ar_open && (owner ? a1_arvalid : a0_arvalid);
    assign mem_rready  = owned && (owner ? a1_rready : a0_rready);

    assign a0_arready = ar_open && !owner && mem_arready;
    assign a1_arready = ar_open && owner && mem_arready;

    // R beats only reach the owner
    assign a0_rdata  = mem_rdata;
    assign a0_rresp  = mem_rresp;
    assign a0_rlast  = mem_rlast;
    assign a0_rvalid = owned && !owner && mem_rvalid;
    assign a1_rdata  = mem_rdata;
    assign a1_rresp  = mem_rresp;
    assign a1_rlast  = mem_rlast;
    assign a1_rvalid = owned && owner && mem_rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            owned       <= 1'b0;
            owner       <= 1'b0;
            ar_sent     <= 1'b0;
            last_winner <= 1'b1;
        end else if (!owned) begin
            if (a0_arvalid || a1_arvalid) begin
                owned <= 1'b1;
                owner <= pick;
            end
        end else begin
            if (mem_arvalid && mem_arready) begin
                ar_sent <= 1'b1;
            end
            // grant released on the last beat
            if (mem_rvalid && mem_rready && mem_rlast) begin
                owned       <= 1'b0;
                ar_sent     <= 1'b0;
                last_winner <= owner;
            end
        end
    end

endmodule

// File: hw/axird_fifo_master.sv
// AXI read master with response FIFO
`timescale 1ns/1ps

module axird_fifo_master (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fifo_rd_flush,
    input  logic                            fifo_wr_flush,
    output logic                            fifo_empty,
    output logic                            fifo_full,
    input  logic [hacd_pkg::addr_width-1:0] s_araddr,
    input  logic [7:0]                      s_arlen,
    input  logic                            s_arvalid,
    output logic                            s_arready,
    output logic [hacd_pkg::data_width-1:0] s_rdata,
    output logic [1:0]                      s_rresp,
    output logic                            s_rlast,
    output logic                            s_rvalid,
    input  logic                            s_rready,
    output logic [hacd_pkg::addr_width-1:0] m_araddr,
    output logic [7:0]                      m_arlen,
    output logic                            m_arvalid,
    input  logic                            m_arready,
    input  logic [hacd_pkg::data_width-1:0] m_rdata,
    input  logic [1:0]                      m_rresp,
    input  logic                            m_rlast,
    input  logic                            m_rvalid,
    output logic                            m_rready
);

    logic [hacd_pkg::fifo_addr_width:0]   wr_ptr;
    logic [hacd_pkg::fifo_addr_width:0]   rd_ptr;
    logic [hacd_pkg::data_width+2:0]      mem [hacd_pkg::fifo_depth];
    logic [hacd_pkg::data_width+2:0]      rd_data;
    logic                                 rd_valid;
    logic [hacd_pkg::data_width+2:0]      out_data;
    logic                                 out_valid;
    logic                                 load_out;
    logic                                 advance_rd;

    logic                                 ar_wait;
    logic                                 ar_wait_next;
    logic                                 m_arvalid_r;
    logic                                 m_arvalid_next;
    logic                                 s_arready_r;
    logic                                 s_arready_next;
    logic [hacd_pkg::addr_width-1:0]      araddr_r;
    logic [7:0]                           arlen_r;
    logic [hacd_pkg::count_width-1:0]     count;
    logic [hacd_pkg::count_width-1:0]     count_next;
    logic                                 load_ar;

    // whole burst must fit next to the beats already promised
    function automatic logic burst_fits(input logic [hacd_pkg::count_width-1:0] used,
                                        input logic [7:0] len);
        return (used == '0) || (used + len + 1 <= hacd_pkg::fifo_depth);
    endfunction

    always_comb begin
        load_ar        = 1'b0;
        ar_wait_next   = ar_wait;
        m_arvalid_next = m_arvalid_r && !m_arready;
        s_arready_next = s_arready_r;
        count_next     = count;
        if (s_arready_r && s_arvalid) begin
            load_ar        = 1'b1;
            s_arready_next = 1'b0;
            if (burst_fits(count, s_arlen)) begin
                count_next     = count + s_arlen + 1'b1;
                m_arvalid_next = 1'b1;
            end else begin
                ar_wait_next = 1'b1;
            end
        end else if (ar_wait) begin
            // held until draining frees space
            if (burst_fits(count, arlen_r)) begin
                count_next     = count + arlen_r + 1'b1;
                m_arvalid_next = 1'b1;
                ar_wait_next   = 1'b0;
            end
        end else begin
            s_arready_next = !m_arvalid_next;
        end
        // space comes back as beats leave toward the engine
        if (out_valid && s_rready) begin
            count_next = count_next - 1'b1;
        end
        if (fifo_wr_flush) begin
            count_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_wait     <= 1'b0;
            m_arvalid_r <= 1'b0;
            s_arready_r <= 1'b0;
            count       <= '0;
        end else begin
            ar_wait     <= ar_wait_next;
            m_arvalid_r <= m_arvalid_next;
            s_arready_r <= s_arready_next;
            count       <= count_next;
        end
        if (load_ar) begin
            araddr_r <= s_araddr;
            arlen_r  <= s_arlen;
        end
    end

    assign s_arready = s_arready_r;
    assign m_arvalid = m_arvalid_r;
    assign m_araddr  = araddr_r;
    assign m_arlen   = arlen_r;

    // extra pointer bit tells full from empty
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[hacd_pkg::fifo_addr_width] != rd_ptr[hacd_pkg::fifo_addr_width])
                     && (wr_ptr[hacd_pkg::fifo_addr_width-1:0]
                         == rd_ptr[hacd_pkg::fifo_addr_width-1:0]);
    assign m_rready   = !fifo_full;

    always_ff @(posedge clk) begin
        if (rst || fifo_wr_flush) begin
            wr_ptr <= '0;
        end else if (m_rvalid && m_rready) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (m_rvalid && m_rready) begin
            mem[wr_ptr[hacd_pkg::fifo_addr_width-1:0]] <= {m_rresp, m_rlast, m_rdata};
        end
    end

    // registered RAM read, then the output register
    assign load_out   = !out_valid || s_rready;
    assign advance_rd = !rd_valid || load_out;

    always_ff @(posedge clk) begin
        if (rst || fifo_rd_flush) begin
            rd_ptr    <= '0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (advance_rd) begin
                rd_valid <= !fifo_empty;
                if (!fifo_empty) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (load_out) begin
                out_valid <= rd_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance_rd && !fifo_empty) begin
            rd_data <= mem[rd_ptr[hacd_pkg::fifo_addr_width-1:0]];
        end
        if (load_out) begin
            out_data <= rd_data;
        end
    end

    assign s_rvalid = out_valid;
    assign s_rdata  = out_data[hacd_pkg::data_width-1:0];
    assign s_rlast  = out_data[hacd_pkg::data_width];
    assign s_rresp  = out_data[hacd_pkg::data_width+2 -: 2];

endmodule

// File: hw/hacd_pkg.sv
// compaction read path constants
package hacd_pkg;

    // AXI read port widths
    localparam int data_width = 32;
    localparam int addr_width = 32;

    // one page is fetched as a single burst
    localparam int page_beats = 16;
    localparam logic [7:0] burst_len = 8'(page_beats - 1);

    // read FIFO holds two whole bursts
    localparam int fifo_depth = 32;
    localparam int fifo_addr_width = $clog2(fifo_depth);

    // promised space, room for a 256-beat request on top of a full FIFO
    localparam int count_width = $clog2(fifo_depth + 256) + 1;

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

// File: hw/hacd_read_top.sv
// compaction read path top
`timescale 1ns/1ps

module hacd_read_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            zs_start,
    input  logic [hacd_pkg::addr_width-1:0] zs_page_addr,
    output logic                            zs_busy,
    output logic                            zs_done,
    output logic                            zs_is_zero,
    output logic                            zs_resp_err,
    input  logic                            ck_start,
    input  logic [hacd_pkg::addr_width-1:0] ck_page_addr,
    output logic                            ck_busy,
    output logic                            ck_done,
    output logic [hacd_pkg::data_width-1:0] ck_sum,
    output logic                            ck_resp_err,
    output logic [hacd_pkg::addr_width-1:0] mem_araddr,
    output logic [7:0]                      mem_arlen,
    output logic                            mem_arvalid,
    input  logic                            mem_arready,
    input  logic [hacd_pkg::data_width-1:0] mem_rdata,
    input  logic [1:0]                      mem_rresp,
    input  logic                            mem_rlast,
    input  logic                            mem_rvalid,
    output logic                            mem_rready
);

    logic [hacd_pkg::addr_width-1:0] zs_e_araddr, zs_m_araddr, ck_e_araddr, ck_m_araddr;
    logic [7:0]                      zs_e_arlen, zs_m_arlen, ck_e_arlen, ck_m_arlen;
    logic [hacd_pkg::data_width-1:0] zs_e_rdata, zs_m_rdata, ck_e_rdata, ck_m_rdata;
    logic [1:0]                      zs_e_rresp, zs_m_rresp, ck_e_rresp, ck_m_rresp;
    // engine to master
    logic zs_e_arvalid, zs_e_arready, zs_e_rlast, zs_e_rvalid, zs_e_rready;
    logic ck_e_arvalid, ck_e_arready, ck_e_rlast, ck_e_rvalid, ck_e_rready;
    logic zs_rd_flush, zs_wr_flush, ck_rd_flush, ck_wr_flush;
    // master to arbiter
    logic zs_m_arvalid, zs_m_arready, zs_m_rlast, zs_m_rvalid, zs_m_rready;
    logic ck_m_arvalid, ck_m_arready, ck_m_rlast, ck_m_rvalid, ck_m_rready;

    page_zero_scan u_zero_scan (
        .clk(clk), .rst(rst), .start(zs_start), .page_addr(zs_page_addr),
        .busy(zs_busy), .done(zs_done), .is_zero(zs_is_zero), .resp_err(zs_resp_err),
        .fifo_rd_flush(zs_rd_flush), .fifo_wr_flush(zs_wr_flush),
        .s_araddr(zs_e_araddr), .s_arlen(zs_e_arlen), .s_arvalid(zs_e_arvalid),
        .s_arready(zs_e_arready), .s_rdata(zs_e_rdata), .s_rresp(zs_e_rresp),
        .s_rlast(zs_e_rlast), .s_rvalid(zs_e_rvalid), .s_rready(zs_e_rready)
    );

    page_checksum u_checksum (
        .clk(clk), .rst(rst), .start(ck_start), .page_addr(ck_page_addr),
        .busy(ck_busy), .done(ck_done), .sum(ck_sum), .resp_err(ck_resp_err),
        .fifo_rd_flush(ck_rd_flush), .fifo_wr_flush(ck_wr_flush),
        .s_araddr(ck_e_araddr), .s_arlen(ck_e_arlen), .s_arvalid(ck_e_arvalid),
        .s_arready(ck_e_arready), .s_rdata(ck_e_rdata), .s_rresp(ck_e_rresp),
        .s_rlast(ck_e_rlast), .s_rvalid(ck_e_rvalid), .s_rready(ck_e_rready)
    );

    axird_fifo_master u_zs_master (
        .clk(clk), .rst(rst), .fifo_rd_flush(zs_rd_flush), .fifo_wr_flush(zs_wr_flush),
        .fifo_empty(), .fifo_full(),
        .s_araddr(zs_e_araddr), .s_arlen(zs_e_arlen), .s_arvalid(zs_e_arvalid),
        .s_arready(zs_e_arready), .s_rdata(zs_e_rdata), .s_rresp(zs_e_rresp),
        .s_rlast(zs_e_rlast), .s_rvalid(zs_e_rvalid), .s_rready(zs_e_rready),
        .m_araddr(zs_m_araddr), .m_arlen(zs_m_arlen), .m_arvalid(zs_m_arvalid),
        .m_arready(zs_m_arready), .m_rdata(zs_m_rdata), .m_rresp(zs_m_rresp),
        .m_rlast(zs_m_rlast), .m_rvalid(zs_m_rvalid), .m_rready(zs_m_rready)
    );

    axird_fifo_master u_ck_master (
        .clk(clk), .rst(rst), .fifo_rd_flush(ck_rd_flush), .fifo_wr_flush(ck_wr_flush),
        .fifo_empty(), .fifo_full(),
        .s_araddr(ck_e_araddr), .s_arlen(ck_e_arlen), .s_arvalid(ck_e_arvalid),
        .s_arready(ck_e_arready), .s_rdata(ck_e_rdata), .s_rresp(ck_e_rresp),
        .s_rlast(ck_e_rlast), .s_rvalid(ck_e_rvalid), .s_rready(ck_e_rready),
        .m_araddr(ck_m_araddr), .m_arlen(ck_m_arlen), .m_arvalid(ck_m_arvalid),
        .m_arready(ck_m_arready), .m_rdata(ck_m_rdata), .m_rresp(ck_m_rresp),
        .m_rlast(ck_m_rlast), .m_rvalid(ck_m_rvalid), .m_rready(ck_m_rready)
    );

    // zero scan on port 0, checksum on port 1
    axird_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .a0_araddr(zs_m_araddr), .a0_arlen(zs_m_arlen), .a0_arvalid(zs_m_arvalid),
        .a0_rready(zs_m_rready), .a0_arready(zs_m_arready), .a0_rdata(zs_m_rdata),
        .a0_rresp(zs_m_rresp), .a0_rlast(zs_m_rlast), .a0_rvalid(zs_m_rvalid),
        .a1_araddr(ck_m_araddr), .a1_arlen(ck_m_arlen), .a1_arvalid(ck_m_arvalid),
        .a1_rready(ck_m_rready), .a1_arready(ck_m_arready), .a1_rdata(ck_m_rdata),
        .a1_rresp(ck_m_rresp), .a1_rlast(ck_m_rlast), .a1_rvalid(ck_m_rvalid),
        .mem_araddr(mem_araddr), .mem_arlen(mem_arlen), .mem_arvalid(mem_arvalid),
        .mem_rready(mem_rready), .mem_arready(mem_arready), .mem_rdata(mem_rdata),
        .mem_rresp(mem_rresp), .mem_rlast(mem_rlast), .mem_rvalid(mem_rvalid)
    );

endmodule

// File: hw/page_checksum.sv
// page checksum engine
`timescale 1ns/1ps

module page_checksum (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [hacd_pkg::addr_width-1:0] page_addr,
    output logic                            busy,
    output logic                            done,
    output logic [hacd_pkg::data_width-1:0] sum,
    output logic                            resp_err,
    output logic                            fifo_rd_flush,
    output logic                            fifo_wr_flush,
    output logic [hacd_pkg::addr_width-1:0] s_araddr,
    output logic [7:0]                      s_arlen,
    output logic                            s_arvalid,
    input  logic                            s_arready,
    input  logic [hacd_pkg::data_width-1:0] s_rdata,
    input  logic [1:0]                      s_rresp,
    input  logic                            s_rlast,
    input  logic                            s_rvalid,
    output logic                            s_rready
);

    logic take_start;
    logic beat;

    assign take_start    = start && !busy;
    assign beat          = s_rvalid && s_rready;
    assign fifo_rd_flush = take_start;
    assign fifo_wr_flush = take_start;
    assign s_arlen       = hacd_pkg::burst_len;
    // one beat per cycle while the job runs
    assign s_rready      = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            s_arvalid <= 1'b0;
        end else begin
            done <= 1'b0;
            if (take_start) begin
                busy      <= 1'b1;
                s_arvalid <= 1'b1;
            end else begin
                if (s_arvalid && s_arready) begin
                    s_arvalid <= 1'b0;
                end
                if (beat && s_rlast) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // sum wraps modulo 2^32
    always_ff @(posedge clk) begin
        if (take_start) begin
            s_araddr <= page_addr;
            sum      <= '0;
            resp_err <= 1'b0;
        end else if (beat) begin
            sum      <= sum + s_rdata;
            resp_err <= resp_err || (s_rresp != hacd_pkg::resp_okay);
        end
    end

endmodule

// File: hw/page_zero_scan.sv
// page zero scan engine
`timescale 1ns/1ps

module page_zero_scan (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic [hacd_pkg::addr_width-1:0] page_addr,
    output logic                            busy,
    output logic                            done,
    output logic                            is_zero,
    output logic                            resp_err,
    output logic                            fifo_rd_flush,
    output logic                            fifo_wr_flush,
    output logic [hacd_pkg::addr_width-1:0] s_araddr,
    output logic [7:0]                      s_arlen,
    output logic                            s_arvalid,
    input  logic                            s_arready,
    input  logic [hacd_pkg::data_width-1:0] s_rdata,
    input  logic [1:0]                      s_rresp,
    input  logic                            s_rlast,
    input  logic                            s_rvalid,
    output logic                            s_rready
);

    logic take_start;
    logic beat;

    assign take_start    = start && !busy;
    assign beat          = s_rvalid && s_rready;
    // stale beats from an earlier job are dropped
    assign fifo_rd_flush = take_start;
    assign fifo_wr_flush = take_start;
    assign s_arlen       = hacd_pkg::burst_len;
    assign s_rready      = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            s_arvalid <= 1'b0;
        end else begin
            done <= 1'b0;
            if (take_start) begin
                busy      <= 1'b1;
                s_arvalid <= 1'b1;
            end else begin
                if (s_arvalid && s_arready) begin
                    s_arvalid <= 1'b0;
                end
                if (beat && s_rlast) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // running flags over the page
    always_ff @(posedge clk) begin
        if (take_start) begin
            s_araddr <= page_addr;
            is_zero  <= 1'b1;
            resp_err <= 1'b0;
        end else if (beat) begin
            is_zero  <= is_zero && (s_rdata == '0);
            resp_err <= resp_err || (s_rresp != hacd_pkg::resp_okay);
        end
    end

endmodule

// File: test/axi_mem_model.sv
// AXI4 read slave model
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          depth    = 256,
    parameter logic [31:0] err_base = 32'hffff_ffff
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_en,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    logic [31:0] words [depth];
    logic [31:0] lfsr;
    logic [31:0] lfsr_next;
    logic        gate;
    logic        busy;
    logic [31:0] beat_addr;
    logic [7:0]  beat_cnt;
    logic [7:0]  len;

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // at most one gate decision per cycle, so one bit per cycle at most
    assign lfsr_next = lfsr_step(lfsr);
    assign gate      = !stall_en || lfsr_next[31];

    assign rdata = words[beat_addr[$clog2(depth)+1:2]];
    assign rresp = (beat_addr >= err_base) ? 2'b10 : 2'b00;
    assign rlast = (beat_cnt == len);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr      <= 32'hfb21c6d4;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            busy      <= 1'b0;
            beat_addr <= '0;
            beat_cnt  <= '0;
            len       <= '0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy      <= 1'b1;
                arready   <= 1'b0;
                beat_addr <= araddr;
                len       <= arlen;
                beat_cnt  <= '0;
                rvalid    <= gate;
            end else begin
                arready <= gate;
            end
            if (stall_en) begin
                lfsr <= lfsr_next;
            end
        end else if (rvalid && rready && rlast) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
        end else if (!rvalid || rready) begin
            if (rvalid) begin
                beat_addr <= beat_addr + 32'd4;
                beat_cnt  <= beat_cnt + 8'd1;
            end
            rvalid <= gate;
            if (stall_en) begin
                lfsr <= lfsr_next;
            end
        end
    end

endmodule

// File: test/tb_hacd_read.sv
// compaction read path testbench
`timescale 1ns/1ps

module tb_hacd_read;

    localparam int mem_words = 256;
    localparam logic [31:0] err_base = 32'h0000_0300;
    localparam int num_tests = 10;
    // tests x 2 pages x beats x stall factor, plus margin
    localparam int cycle_limit = num_tests * 2 * hacd_pkg::page_beats * 8 + 1000;

    logic                            clk;
    logic                            rst;
    logic                            zs_start;
    logic [hacd_pkg::addr_width-1:0] zs_page_addr;
    logic                            zs_busy;
    logic                            zs_done;
    logic                            zs_is_zero;
    logic                            zs_resp_err;
    logic                            ck_start;
    logic [hacd_pkg::addr_width-1:0] ck_page_addr;
    logic                            ck_busy;
    logic                            ck_done;
    logic [hacd_pkg::data_width-1:0] ck_sum;
    logic                            ck_resp_err;
    logic [hacd_pkg::addr_width-1:0] mem_araddr;
    logic [7:0]                      mem_arlen;
    logic                            mem_arvalid;
    logic                            mem_arready;
    logic [hacd_pkg::data_width-1:0] mem_rdata;
    logic [1:0]                      mem_rresp;
    logic                            mem_rlast;
    logic                            mem_rvalid;
    logic                            mem_rready;
    logic                            stall_en;

    logic [31:0] ref_words [mem_words];
    logic        exp_zero;
    logic        exp_zs_err;
    logic        exp_ck_err;
    logic [31:0] exp_sum;
    logic        started;
    int          open_bursts = 0;
    int          zs_dones = 0;
    int          ck_dones = 0;
    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;

    hacd_read_top DUT (
        .clk(clk), .rst(rst),
        .zs_start(zs_start), .zs_page_addr(zs_page_addr), .zs_busy(zs_busy),
        .zs_done(zs_done), .zs_is_zero(zs_is_zero), .zs_resp_err(zs_resp_err),
        .ck_start(ck_start), .ck_page_addr(ck_page_addr), .ck_busy(ck_busy),
        .ck_done(ck_done), .ck_sum(ck_sum), .ck_resp_err(ck_resp_err),
        .mem_araddr(mem_araddr), .mem_arlen(mem_arlen), .mem_arvalid(mem_arvalid),
        .mem_arready(mem_arready), .mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
        .mem_rlast(mem_rlast), .mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
    );

    axi_mem_model #(.depth(mem_words), .err_base(err_base)) u_mem (
        .clk(clk), .rst(rst), .stall_en(stall_en),
        .araddr(mem_araddr), .arlen(mem_arlen), .arvalid(mem_arvalid),
        .arready(mem_arready), .rdata(mem_rdata), .rresp(mem_rresp),
        .rlast(mem_rlast), .rvalid(mem_rvalid), .rready(mem_rready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // every word depends on its full byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic expected_zero(input logic [31:0] addr);
        int base;
        logic all_zero;
        base = int'(addr >> 2);
        all_zero = 1'b1;
        for (int i = 0; i < hacd_pkg::page_beats; i++) begin
            all_zero = all_zero && (ref_words[base + i] == 32'd0);
        end
        return all_zero;
    endfunction

    function automatic logic [31:0] expected_sum(input logic [31:0] addr);
        int base;
        logic [31:0] total;
        base = int'(addr >> 2);
        total = 32'd0;
        for (int i = 0; i < hacd_pkg::page_beats; i++) begin
            total = total + ref_words[base + i];
        end
        return total;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    // done counts, burst tracking on the shared port
    always @(posedge clk) begin
        if (zs_done) begin
            zs_dones <= zs_dones + 1;
        end
        if (ck_done) begin
            ck_dones <= ck_dones + 1;
        end
        if (rst) begin
            started     <= 1'b0;
            open_bursts <= 0;
        end else begin
            if (zs_start || ck_start) begin
                started <= 1'b1;
            end
            open_bursts <= open_bursts + int'(mem_arvalid && mem_arready)
                         - int'(mem_rvalid && mem_rready && mem_rlast);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: jobs did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    zs_result: assert property (@(posedge clk) disable iff (rst)
        zs_done |-> (zs_is_zero == exp_zero) && (zs_resp_err == exp_zs_err))
        else report_mismatch($sformatf("zero scan is_zero %0b resp_err %0b, expected %0b %0b",
            $sampled(zs_is_zero), $sampled(zs_resp_err), exp_zero, exp_zs_err));

    ck_result: assert property (@(posedge clk) disable iff (rst)
        ck_done |-> (ck_sum == exp_sum) && (ck_resp_err == exp_ck_err))
        else report_mismatch($sformatf("checksum sum %h resp_err %0b, expected %h %0b",
            $sampled(ck_sum), $sampled(ck_resp_err), exp_sum, exp_ck_err));

    one_burst: assert property (@(posedge clk) disable iff (rst)
        mem_arvalid |-> (open_bursts == 0))
        else report_mismatch("new read address while a burst is still open");

    // one page per request, at the address of a running job
    ar_request: assert property (@(posedge clk) disable iff (rst)
        mem_arvalid |-> (int'(mem_arlen) + 1 == hacd_pkg::page_beats)
            && ((zs_busy && (mem_araddr == zs_page_addr))
                || (ck_busy && (mem_araddr == ck_page_addr))))
        else report_mismatch($sformatf("read address %h len %0d matches no started page",
            $sampled(mem_araddr), $sampled(mem_arlen)));

    zs_pulse: assert property (@(posedge clk) disable iff (rst) zs_done |=> !zs_done)
        else report_mismatch("zs_done longer than one cycle");

    ck_pulse: assert property (@(posedge clk) disable iff (rst) ck_done |=> !ck_done)
        else report_mismatch("ck_done longer than one cycle");

    zs_busy_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(zs_busy) |-> $past(zs_start))
        else report_mismatch("zs_busy rose without a start");

    zs_busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(zs_busy) |-> zs_done)
        else report_mismatch("zs_busy fell without zs_done");

    ck_busy_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(ck_busy) |-> $past(ck_start))
        else report_mismatch("ck_busy rose without a start");

    ck_busy_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(ck_busy) |-> ck_done)
        else report_mismatch("ck_busy fell without ck_done");

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !mem_arvalid && !mem_rready && !zs_busy && !ck_busy
            && !zs_done && !ck_done)
        else report_mismatch("activity before the first start");

    // start cycle per engine
    // an offset of -1 leaves that engine idle
    task automatic run_job(input string name, input int zs_at, input logic [31:0] zaddr,
                           input int ck_at, input logic [31:0] caddr);
        int zs_before;
        int ck_before;
        int err_before;
        int cyc;
        zs_before  = zs_dones;
        ck_before  = ck_dones;
        err_before = errors;
        for (cyc = 0; cyc < 2; cyc++) begin
            @(negedge clk);
            zs_start = (zs_at == cyc);
            ck_start = (ck_at == cyc);
            if (zs_at == cyc) begin
                zs_page_addr = zaddr;
                exp_zero     = expected_zero(zaddr);
                exp_zs_err   = (zaddr >= err_base);
            end
            if (ck_at == cyc) begin
                ck_page_addr = caddr;
                exp_sum      = expected_sum(caddr);
                exp_ck_err   = (caddr >= err_base);
            end
        end
        @(negedge clk);
        zs_start = 1'b0;
        ck_start = 1'b0;
        while (((zs_at >= 0) && (zs_dones == zs_before))
               || ((ck_at >= 0) && (ck_dones == ck_before))) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        rst          = 1'b1;
        zs_start     = 1'b0;
        zs_page_addr = '0;
        ck_start     = 1'b0;
        ck_page_addr = '0;
        stall_en     = 1'b0;
        exp_zero     = 1'b0;
        exp_zs_err   = 1'b0;
        exp_ck_err   = 1'b0;
        exp_sum      = '0;
        for (int i = 0; i < mem_words; i++) begin
            ref_words[i] = fill_word(32'(i * 4));
        end
        // page 0x040 all zero, page 0x080 zero but one word
        for (int i = 16; i < 48; i++) begin
            ref_words[i] = 32'd0;
        end
        ref_words[37] = 32'h0000_0100;
        for (int i = 0; i < mem_words; i++) begin
            u_mem.words[i] = ref_words[i];
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        run_job("zero page", 0, 32'h040, -1, 32'h0);
        run_job("one nonzero word", 0, 32'h080, -1, 32'h0);
        run_job("checksum", -1, 32'h0, 0, 32'h0c0);
        run_job("same cycle", 0, 32'h040, 0, 32'h100);
        run_job("zero scan leads", 0, 32'h000, 1, 32'h140);
        run_job("checksum leads", 1, 32'h180, 0, 32'h1c0);
        stall_en = 1'b1;
        run_job("stalls same cycle", 0, 32'h040, 0, 32'h100);
        run_job("stalls shifted", 0, 32'h080, 1, 32'h200);
        run_job("error pages", 0, 32'h300, 0, 32'h340);
        run_job("recovery", 0, 32'h040, 0, 32'h240);

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
